//--- common/aluPkg.sv
package aluPkg;

	// Width of the short instruction argument fields.
	localparam int argWidth = 4;

	// Operation codes. The two codes without a name pass A through.
	typedef enum logic [3:0] {
		opAdd   = 4'h0, // A plus B.
		opAdc   = 4'h1, // A plus B plus the latched carry.
		opSub   = 4'h2, // A minus B.
		opSbc   = 4'h3, // A minus B minus the latched borrow.
		opAnd   = 4'h4,
		opOr    = 4'h5,
		opXor   = 4'h6,
		opNot   = 4'h7, // Inverts A.
		opShl   = 4'h8, // Shift left by one, zero fill.
		opShr   = 4'h9, // Logical shift right by one.
		opAsr   = 4'ha, // Arithmetic shift right, the sign bit is kept.
		opRol   = 4'hb,
		opRor   = 4'hc,
		opPassB = 4'hd
	} aluOp_t;

	// Where the A operand comes from.
	typedef enum logic [1:0] {
		srcARegA = 2'b00, // Data input A.
		srcAArg  = 2'b01, // Argument A, zero-extended.
		srcAZero = 2'b10,
		srcAOnes = 2'b11
	} srcA_t;

	// Where the B operand comes from. Codes above srcBZero also give zero.
	typedef enum logic [2:0] {
		srcBRegB = 3'b000, // Data input B.
		srcBArg  = 3'b001, // Argument B, zero-extended.
		srcBOne  = 3'b010,
		srcBIncr = 3'b011, // Load/store increment from the increment field.
		srcBZero = 3'b100
	} srcB_t;

	// Condition codes as held in the latch.
	// Parity is set when the result holds an odd number of ones.
	typedef struct packed {
		logic zero;
		logic carry;
		logic sign;
		logic parity;
	} ccFlags_t;

	// Control word that travels down the pipeline with its operands.
	typedef struct packed {
		aluOp_t op;
		logic   ccLoad;
	} aluCtrl_t;

endpackage

//--- fullAlu/operandSelect.sv
`timescale 1ns/10ps

// First pipeline stage.
// Picks the A and B operands from their sources and registers them together
// with the operation and the flag load strobe.
module operandSelect #(
	parameter int dataWidth = 16
) (
	input  logic                        CLK,
	input  logic                        arstN,
	input  logic [dataWidth-1:0]        aluADin,
	input  logic [dataWidth-1:0]        aluBDin,
	input  aluPkg::srcA_t               srcA,
	input  aluPkg::srcB_t               srcB,
	input  logic [aluPkg::argWidth-1:0] argA,
	input  logic [aluPkg::argWidth-1:0] argB,
	input  logic [1:0]                  ldsIncF,
	input  aluPkg::aluOp_t              aluOp,
	input  logic                        ccLoad,
	output logic [dataWidth-1:0]        opA,
	output logic [dataWidth-1:0]        opB,
	output aluPkg::aluCtrl_t            ctrlS1
);
	import aluPkg::*;

	logic [dataWidth-1:0] incr;
	logic [dataWidth-1:0] nextA;
	logic [dataWidth-1:0] nextB;

	// Increment used by loads and stores that walk the stack.
	always_comb begin
		case (ldsIncF)
			2'b00:   incr = '0;
			2'b01:   incr = dataWidth'(1);
			2'b10:   incr = dataWidth'(2);
			default: incr = '1; // All ones, so the pointer steps down by one.
		endcase
	end

	always_comb begin
		case (srcA)
			srcARegA: nextA = aluADin;
			srcAArg:  nextA = {{(dataWidth-argWidth){1'b0}}, argA};
			srcAZero: nextA = '0;
			srcAOnes: nextA = '1;
			default:  nextA = '0;
		endcase
	end

	always_comb begin
		case (srcB)
			srcBRegB: nextB = aluBDin;
			srcBArg:  nextB = {{(dataWidth-argWidth){1'b0}}, argB};
			srcBOne:  nextB = dataWidth'(1);
			srcBIncr: nextB = incr;
			srcBZero: nextB = '0;
			default:  nextB = '0; // Spare codes read as zero.
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			opA    <= '0;
			opB    <= '0;
			ctrlS1 <= '0; // Clears ccLoad so nothing reaches the flags.
		end else begin
			opA    <= nextA;
			opB    <= nextB;
			ctrlS1 <= aluCtrl_t'{op: aluOp, ccLoad: ccLoad};
		end
	end

	// Selects and the increment field must be driven to known levels
	// whenever the pipeline is running.
	selKnown: assert property (@(posedge CLK) disable iff (!arstN)
		!$isunknown({srcA, srcB, ldsIncF}))
		else $error("operandSelect: unknown source select or increment field");

endmodule

//--- fullAlu/aluExecute.sv
`timescale 1ns/10ps

// Second pipeline stage.
// Computes the result and the candidate condition codes from the registered
// operands. The result is registered, the flags go on to the latch.
module aluExecute #(
	parameter int dataWidth = 16
) (
	input  logic                 CLK,
	input  logic                 arstN,
	input  logic [dataWidth-1:0] opA,
	input  logic [dataWidth-1:0] opB,
	input  aluPkg::aluCtrl_t     ctrlS1,
	input  logic                 carryIn,
	output logic [dataWidth-1:0] aluR,
	output aluPkg::ccFlags_t     nextFlags,
	output logic                 ccLoadS2
);
	import aluPkg::*;

	logic                 isSub;
	logic                 addCin;
	logic [dataWidth-1:0] addB;
	logic [dataWidth:0]   addSum;
	logic [dataWidth-1:0] result;
	logic                 carryOut;

	// One adder serves add and subtract. Subtract adds the inverted B with a
	// carry in of one, so the adder's carry out is the inverse of a borrow.
	always_comb begin
		isSub = (ctrlS1.op == opSub) || (ctrlS1.op == opSbc);
		addB  = isSub ? ~opB : opB;
		case (ctrlS1.op)
			opAdc:   addCin = carryIn;
			opSub:   addCin = 1'b1;
			opSbc:   addCin = ~carryIn; // A pending borrow takes one more away.
			default: addCin = 1'b0;
		endcase
		addSum = {1'b0, opA} + {1'b0, addB} + {{dataWidth{1'b0}}, addCin};
	end

	always_comb begin
		result   = opA;
		carryOut = 1'b0; // Logic and pass operations leave carry clear.
		case (ctrlS1.op)
			opAdd, opAdc: begin
				result   = addSum[dataWidth-1:0];
				carryOut = addSum[dataWidth];
			end
			opSub, opSbc: begin
				result   = addSum[dataWidth-1:0];
				carryOut = ~addSum[dataWidth]; // Set when a borrow occurred.
			end
			opAnd: result = opA & opB;
			opOr:  result = opA | opB;
			opXor: result = opA ^ opB;
			opNot: result = ~opA;
			opShl: begin
				result   = {opA[dataWidth-2:0], 1'b0};
				carryOut = opA[dataWidth-1];
			end
			opShr: begin
				result   = {1'b0, opA[dataWidth-1:1]};
				carryOut = opA[0];
			end
			opAsr: begin
				result   = {opA[dataWidth-1], opA[dataWidth-1:1]};
				carryOut = opA[0];
			end
			opRol: begin
				result   = {opA[dataWidth-2:0], opA[dataWidth-1]};
				carryOut = opA[dataWidth-1];
			end
			opRor: begin
				result   = {opA[0], opA[dataWidth-1:1]};
				carryOut = opA[0];
			end
			opPassB: result = opB;
			default: result = opA;
		endcase
	end

	// Candidate flags come straight from the unregistered result.
	assign nextFlags = ccFlags_t'{
		zero:   (result == '0),
		carry:  carryOut,
		sign:   result[dataWidth-1],
		parity: ^result
	};

	assign ccLoadS2 = ctrlS1.ccLoad;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			aluR <= '0;
		end else begin
			aluR <= result;
		end
	end

	// Subtract and exclusive-or give a zero result exactly when the operands
	// are equal, so the zero flag must follow operand equality for them.
	zeroOnEqual: assert property (@(posedge CLK) disable iff (!arstN)
		((ctrlS1.op == opSub) || (ctrlS1.op == opXor)) |-> (nextFlags.zero == (opA == opB)))
		else $error("aluExecute: zero flag disagrees with operand equality");

endmodule

//--- fullAlu/condCodeLatch.sv
`timescale 1ns/10ps

// Condition-code register.
// Loads all four flags at once, but only on the strobe that came down the
// pipeline with the operation that produced them.
module condCodeLatch (
	input  logic             CLK,
	input  logic             arstN,
	input  aluPkg::ccFlags_t nextFlags,
	input  logic             ccLoadS2,
	output aluPkg::ccFlags_t flags
);

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			flags <= '0;
		end else if (ccLoadS2) begin
			flags <= nextFlags; // Carry feeds back to the next ADC or SBC.
		end
	end

	// Without a strobe the stored flags must ride through the next cycle.
	flagsHold: assert property (@(posedge CLK) disable iff (!arstN)
		!ccLoadS2 |=> $stable(flags))
		else $error("condCodeLatch: flags changed without a load strobe");

endmodule

//--- fullAlu/fullAlu.sv
`timescale 1ns/10ps

// Pipelined ALU of the stack machine.
// Operand selection, execution and the condition-code latch, two edges from
// input to result.
module fullAlu #(
	parameter int dataWidth = 16
) (
	input  logic                        CLK,
	input  logic                        arstN,
	input  logic [dataWidth-1:0]        aluADin,
	input  logic [dataWidth-1:0]        aluBDin,
	input  aluPkg::aluOp_t              aluOp,
	input  aluPkg::srcA_t               srcA,
	input  aluPkg::srcB_t               srcB,
	input  logic [aluPkg::argWidth-1:0] argA,
	input  logic [aluPkg::argWidth-1:0] argB,
	input  logic [1:0]                  ldsIncF,
	input  logic                        ccLoad,
	output logic [dataWidth-1:0]        aluR,
	output logic [dataWidth-1:0]        aluAData,
	output logic [dataWidth-1:0]        aluBData,
	output logic                        ccZero,
	output logic                        ccCarry,
	output logic                        ccSign,
	output logic                        ccParity
);
	import aluPkg::*;

	aluCtrl_t ctrlS1;
	ccFlags_t nextFlags;
	ccFlags_t flags;
	logic     ccLoadS2;

	// The staged operands are also visible at the top.
	operandSelect #(.dataWidth(dataWidth)) operandSelectInst (
		.CLK     (CLK),
		.arstN   (arstN),
		.aluADin (aluADin),
		.aluBDin (aluBDin),
		.srcA    (srcA),
		.srcB    (srcB),
		.argA    (argA),
		.argB    (argB),
		.ldsIncF (ldsIncF),
		.aluOp   (aluOp),
		.ccLoad  (ccLoad),
		.opA     (aluAData),
		.opB     (aluBData),
		.ctrlS1  (ctrlS1)
	);

	aluExecute #(.dataWidth(dataWidth)) aluExecuteInst (
		.CLK       (CLK),
		.arstN     (arstN),
		.opA       (aluAData),
		.opB       (aluBData),
		.ctrlS1    (ctrlS1),
		.carryIn   (flags.carry),
		.aluR      (aluR),
		.nextFlags (nextFlags),
		.ccLoadS2  (ccLoadS2)
	);

	condCodeLatch condCodeLatchInst (
		.CLK       (CLK),
		.arstN     (arstN),
		.nextFlags (nextFlags),
		.ccLoadS2  (ccLoadS2),
		.flags     (flags)
	);

	assign ccZero   = flags.zero;
	assign ccCarry  = flags.carry;
	assign ccSign   = flags.sign;
	assign ccParity = flags.parity;

endmodule

//--- verif/fullAluModel.svh
`ifndef FULL_ALU_MODEL_SVH
`define FULL_ALU_MODEL_SVH

// Expected result and condition codes of one ALU operation.
// The including module supplies dataWidth and imports aluPkg.
typedef struct packed {
	logic [dataWidth-1:0] value;
	ccFlags_t             flags;
} aluResult_t;

function automatic aluResult_t referenceAlu(input logic [3:0] op,
	input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b, input logic carryIn);
	aluResult_t         r;
	logic [dataWidth:0] wide;
	int                 ones;
	r.value       = a;
	r.flags.carry = 1'b0; // Anything that is not arithmetic or a shift clears carry.
	case (op)
		opAdd, opAdc: begin
			wide          = {1'b0, a} + {1'b0, b} + ((op == opAdc) ? carryIn : 1'b0);
			r.value       = wide[dataWidth-1:0];
			r.flags.carry = wide[dataWidth];
		end
		opSub: begin
			r.value       = a - b;
			r.flags.carry = (a < b); // Carry reports a borrow.
		end
		opSbc: begin
			r.value       = a - b - dataWidth'(carryIn);
			r.flags.carry = ({1'b0, a} < ({1'b0, b} + carryIn));
		end
		opAnd: r.value = a & b;
		opOr:  r.value = a | b;
		opXor: r.value = a ^ b;
		opNot: r.value = ~a;
		opShl: begin
			r.value       = a << 1;
			r.flags.carry = a[dataWidth-1];
		end
		opShr: begin
			r.value       = a >> 1;
			r.flags.carry = a[0];
		end
		opAsr: begin
			r.value       = $signed(a) >>> 1;
			r.flags.carry = a[0];
		end
		opRol: begin
			r.value       = (a << 1) | (a >> (dataWidth - 1));
			r.flags.carry = a[dataWidth-1];
		end
		opRor: begin
			r.value       = (a >> 1) | (a << (dataWidth - 1));
			r.flags.carry = a[0];
		end
		opPassB: r.value = b;
		default: r.value = a;
	endcase
	ones = 0;
	for (int i = 0; i < dataWidth; i++) begin
		ones += r.value[i];
	end
	r.flags.zero   = (r.value == '0);
	r.flags.sign   = r.value[dataWidth-1];
	r.flags.parity = ones[0]; // Odd number of ones.
	return r;
endfunction

`endif

//--- verif/fullAluTb.sv
`timescale 1ns/10ps

module fullAluTb;
	import aluPkg::*;

	localparam int dataWidth = 16;
	localparam int clkPeriod = 100;
	// Roughly 600 cycles of vectors, reset and drain, plus margin.
	localparam int maxCycles = 700;

	`include "fullAluModel.svh"

	logic                 CLK;
	logic                 arstN;
	logic [dataWidth-1:0] aluADin;
	logic [dataWidth-1:0] aluBDin;
	aluOp_t               aluOp;
	srcA_t                srcA;
	srcB_t                srcB;
	logic [argWidth-1:0]  argA;
	logic [argWidth-1:0]  argB;
	logic [1:0]           ldsIncF;
	logic                 ccLoad;
	logic [dataWidth-1:0] aluR;
	logic [dataWidth-1:0] aluAData;
	logic [dataWidth-1:0] aluBData;
	logic                 ccZero;
	logic                 ccCarry;
	logic                 ccSign;
	logic                 ccParity;
	logic [3:0]           dutFlags;

	// Expected pipeline state.
	logic [dataWidth-1:0] modelA;
	logic [dataWidth-1:0] modelB;
	logic [3:0]           modelOp;
	logic                 modelLoad;
	logic [dataWidth-1:0] modelR;
	ccFlags_t             modelFlags;
	aluResult_t           stageOut;
	ccFlags_t             heldFlags;

	integer seed;
	int     checkCount;
	int     errorCount;
	int     cycleCount;

	assign dutFlags = {ccZero, ccCarry, ccSign, ccParity};

	fullAlu #(.dataWidth(dataWidth)) UUT (.*);

	initial begin
		CLK = 1'b0;
		forever #(clkPeriod / 2) CLK = ~CLK;
	end

	function automatic logic [dataWidth-1:0] formA(input srcA_t sel,
		input logic [dataWidth-1:0] din, input logic [argWidth-1:0] arg);
		case (sel)
			srcARegA: return din;
			srcAArg:  return dataWidth'(arg);
			srcAZero: return '0;
			default:  return '1;
		endcase
	endfunction

	function automatic logic [dataWidth-1:0] formB(input srcB_t sel,
		input logic [dataWidth-1:0] din, input logic [argWidth-1:0] arg, input logic [1:0] inc);
		case (sel)
			srcBRegB: return din;
			srcBArg:  return dataWidth'(arg);
			srcBOne:  return dataWidth'(1);
			srcBIncr: return (inc == 2'b11) ? '1 : dataWidth'(inc); // 11 steps down by one.
			default:  return '0;
		endcase
	endfunction

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED at %0d ns: %s, expected %h, got %h", $time, what, expected,
				actual);
		end
	endtask

	task automatic checkZero(input string what);
		checkValue(aluR, '0, {what, ": aluR"});
		checkValue(aluAData, '0, {what, ": aluAData"});
		checkValue(aluBData, '0, {what, ": aluBData"});
		checkValue(dutFlags, '0, {what, ": flags"});
	endtask

	task automatic applyOp(input aluOp_t op, input srcA_t selA, input srcB_t selB,
		input logic [dataWidth-1:0] dinA, input logic [dataWidth-1:0] dinB,
		input logic [argWidth-1:0] aA, input logic [argWidth-1:0] aB,
		input logic [1:0] incF, input logic load);
		@(negedge CLK);
		aluOp   = op;
		srcA    = selA;
		srcB    = selB;
		aluADin = dinA;
		aluBDin = dinB;
		argA    = aA;
		argB    = aB;
		ldsIncF = incF;
		ccLoad  = load;
	endtask

	task automatic idleOp();
		applyOp(opAdd, srcAZero, srcBZero, '0, '0, '0, '0, 2'b00, 1'b0);
	endtask

	task automatic randomOp(input logic [3:0] op, input logic load);
		applyOp(aluOp_t'(op), srcARegA, srcBRegB, dataWidth'($random(seed)),
			dataWidth'($random(seed)), '0, '0, 2'b00, load);
	endtask

	// Mirrors the two stages. Execute uses the flags from before this edge.
	always @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			modelA     <= '0;
			modelB     <= '0;
			modelOp    <= '0;
			modelLoad  <= 1'b0;
			modelR     <= '0;
			modelFlags <= '0;
		end else begin
			stageOut = referenceAlu(modelOp, modelA, modelB, modelFlags.carry);
			modelR <= stageOut.value;
			if (modelLoad) begin
				modelFlags <= stageOut.flags;
			end
			modelA    <= formA(srcA, aluADin, argA);
			modelB    <= formB(srcB, aluBDin, argB, ldsIncF);
			modelOp   <= aluOp;
			modelLoad <= ccLoad;
		end
	end

	// Sample a quarter period after the falling edge, well away from any clock edge.
	always @(negedge CLK) begin
		#(clkPeriod / 4);
		checkValue(aluAData, modelA, "staged operand A");
		checkValue(aluBData, modelB, "staged operand B");
		checkValue(aluR, modelR, "result");
		checkValue(dutFlags, modelFlags, "condition codes");
	end

	always @(posedge CLK) begin
		cycleCount++;
		if (cycleCount >= maxCycles) begin
			$display("ERROR: simulation timed out after %0d cycles", cycleCount);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		seed       = 84;
		checkCount = 0;
		errorCount = 0;
		cycleCount = 0;
		arstN      = 1'b0;
		aluADin    = '0;
		aluBDin    = '0;
		aluOp      = opAdd;
		srcA       = srcARegA;
		srcB       = srcBRegB;
		argA       = '0;
		argB       = '0;
		ldsIncF    = 2'b00;
		ccLoad     = 1'b0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		arstN = 1'b1;
		checkZero("after reset");

		applyOp(opAdd, srcARegA, srcBRegB, 16'h1234, 16'h4321, '0, '0, 2'b00, 1'b1);
		idleOp();
		idleOp();
		checkValue(aluR, 16'h5555, "1234 + 4321");
		checkValue(dutFlags, 4'b0000, "flags of 1234 + 4321");
		applyOp(opAdd, srcARegA, srcBRegB, 16'hffff, 16'hffff, '0, '0, 2'b00, 1'b0);
		idleOp();
		idleOp();
		checkValue(aluR, 16'hfffe, "ffff + ffff");
		checkValue(dutFlags, 4'b0000, "flags held without load");
		applyOp(opAdd, srcARegA, srcBRegB, 16'hffff, 16'hffff, '0, '0, 2'b00, 1'b1);
		idleOp();
		idleOp();
		checkValue(dutFlags, 4'b0111, "carry, sign and parity of ffff + ffff");

		// ADC right behind the operation whose carry it needs.
		applyOp(opAdd, srcARegA, srcBRegB, 16'hffff, 16'h0001, '0, '0, 2'b00, 1'b1);
		applyOp(opAdc, srcAZero, srcBZero, '0, '0, '0, '0, 2'b00, 1'b1);
		idleOp();
		idleOp();
		checkValue(aluR, 16'h0001, "ADC after a carry out");

		for (int i = 0; i < 200; i++) begin
			randomOp(4'($random(seed)) & 4'h3, 1'($random(seed)));
		end
		for (int op = 0; op < 16; op++) begin
			repeat (10) randomOp(4'(op), 1'($random(seed)));
		end
		for (int a = 0; a < 4; a++) begin
			for (int b = 0; b < 8; b++) begin
				for (int i = 0; i < 4; i++) begin
					applyOp(aluOp_t'(4'($random(seed))), srcA_t'(2'(a)), srcB_t'(3'(b)),
						dataWidth'($random(seed)), dataWidth'($random(seed)),
						4'($random(seed)), 4'($random(seed)), 2'(i), 1'($random(seed)));
				end
			end
		end

		randomOp(4'h0, 1'b1);
		idleOp();
		idleOp();
		heldFlags = modelFlags;
		repeat (38) randomOp(4'($random(seed)), 1'b0);
		checkValue(dutFlags, heldFlags, "flags held through a run with ccLoad low");
		repeat (10) begin
			randomOp(4'($random(seed)), 1'b1);
			randomOp(4'($random(seed)), 1'b0);
			randomOp(4'($random(seed)), 1'b0);
		end

		repeat (10) randomOp(4'($random(seed)), 1'b1);
		@(negedge CLK);
		arstN = 1'b0;
		#1;
		checkZero("reset in mid-stream");
		@(negedge CLK);
		arstN = 1'b1;
		repeat (10) randomOp(4'($random(seed)), 1'($random(seed)));
		repeat (3) idleOp();

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+verif
common/aluPkg.sv
fullAlu/operandSelect.sv
fullAlu/aluExecute.sv
fullAlu/condCodeLatch.sv
fullAlu/fullAlu.sv
verif/fullAluTb.sv
